// ==== logic/frame_flush.sv ====
`timescale 1ns/1ps

module frame_flush (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush_start,
    output logic                 flush_done,
    output render_pkg::fb_addr_t draw_rd_addr,
    input  render_pkg::pixel_t   draw_rd_data,
    output logic                 disp_wr_en,
    output render_pkg::fb_addr_t disp_wr_addr,
    output render_pkg::pixel_t   disp_wr_data
);

    // Address on the read port is live
    logic                 rd_valid;
    // Read data for data_addr is on draw_rd_data
    logic                 data_valid;
    render_pkg::fb_addr_t data_addr;
    logic                 last_word;

    assign last_word = (data_addr == render_pkg::fb_addr_t'(render_pkg::FB_DEPTH - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid     <= 1'b0;
            draw_rd_addr <= '0;
            data_valid   <= 1'b0;
            disp_wr_en   <= 1'b0;
            flush_done   <= 1'b0;
        end else begin
            flush_done <= 1'b0;
            data_valid <= rd_valid;
            disp_wr_en <= data_valid;

            if (flush_start) begin
                rd_valid     <= 1'b1;
                draw_rd_addr <= '0;
            end else if (rd_valid) begin
                if (draw_rd_addr == render_pkg::fb_addr_t'(render_pkg::FB_DEPTH - 1)) begin
                    rd_valid <= 1'b0;
                end else begin
                    draw_rd_addr <= draw_rd_addr + 1'b1;
                end
            end

            if (data_valid && last_word) begin
                flush_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        data_addr    <= draw_rd_addr;
        disp_wr_addr <= data_addr;
        disp_wr_data <= draw_rd_data;
    end

endmodule

// ==== logic/frame_ram.sv ====
`timescale 1ns/1ps

module frame_ram #(
    parameter int DEPTH = 76800,
    parameter int WIDTH = 6
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    input  logic [WIDTH-1:0]         wr_data,
    output logic [WIDTH-1:0]         rd_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    // One write and one registered read per cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== logic/pixel_out.sv ====
`timescale 1ns/1ps

module pixel_out (
    input  logic                 clk,
    input  logic                 rst_n,
    input  render_pkg::pix_x_t   pixel_x,
    input  render_pkg::pix_y_t   pixel_y,
    output render_pkg::fb_addr_t disp_rd_addr,
    input  render_pkg::pixel_t   disp_rd_data,
    output render_pkg::channel_t red,
    output render_pkg::channel_t green,
    output render_pkg::channel_t blue
);

    render_pkg::pix_x_t x_prev;
    render_pkg::pix_y_t y_prev;
    logic               reading;

    // Column-major lookup
    assign disp_rd_addr = render_pkg::fb_addr_t'(pixel_x * render_pkg::SCREEN_H + pixel_y);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_prev  <= '1;
            y_prev  <= '1;
            reading <= 1'b0;
            red     <= '0;
            green   <= '0;
            blue    <= '0;
        end else if (x_prev != pixel_x || y_prev != pixel_y) begin
            x_prev  <= pixel_x;
            y_prev  <= pixel_y;
            reading <= 1'b1;
        end else if (reading) begin
            // RAM output now belongs to the new coordinate
            red     <= render_pkg::channel_t'(disp_rd_data[5:4] * render_pkg::COLOR_SCALE);
            green   <= render_pkg::channel_t'(disp_rd_data[3:2] * render_pkg::COLOR_SCALE);
            blue    <= render_pkg::channel_t'(disp_rd_data[1:0] * render_pkg::COLOR_SCALE);
            reading <= 1'b0;
        end
    end

endmodule

// ==== logic/plot_engine.sv ====
`timescale 1ns/1ps

module plot_engine (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  plot_start,
    input  render_pkg::coord_t    mid_x,
    input  render_pkg::coord_t    mid_y,
    input  render_pkg::tex_code_t tex_code,
    input  render_pkg::pixel_t    sprite_color,
    output logic                  plot_done,
    output logic                  draw_wr_en,
    output render_pkg::fb_addr_t  draw_wr_addr,
    output render_pkg::pixel_t    draw_wr_data
);

    render_pkg::plot_state_t state;
    render_pkg::fb_addr_t    cnt;

    // Sprite texels, column-major, transparency bit on top
    render_pkg::texel_t sprite_rom [render_pkg::SPRITE_SIZE * render_pkg::SPRITE_SIZE];
    render_pkg::texel_t rom_q;

    // Sprite walker, one texel per cycle
    render_pkg::coord_t   spr_x;
    render_pkg::coord_t   spr_y;
    logic                 spr_on;
    render_pkg::fb_addr_t spr_addr;
    logic                 s1_hit;
    render_pkg::fb_addr_t s1_addr;

    initial begin
        $readmemh("logic/sprite.hex", sprite_rom);
    end

    // cnt[5:3] picks the column, cnt[2:0] the row
    always_comb begin
        spr_x = mid_x - render_pkg::coord_t'(render_pkg::SPRITE_HALF)
              + render_pkg::coord_t'(cnt[5:3]);
        spr_y = mid_y - render_pkg::coord_t'(render_pkg::SPRITE_HALF)
              + render_pkg::coord_t'(cnt[2:0]);
        spr_on = (spr_x >= 0) && (spr_x < render_pkg::SCREEN_W)
              && (spr_y >= 0) && (spr_y < render_pkg::SCREEN_H);
        spr_addr = render_pkg::fb_addr_t'(spr_x * render_pkg::SCREEN_H + spr_y);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= render_pkg::IDLE;
            cnt        <= '0;
            plot_done  <= 1'b0;
            draw_wr_en <= 1'b0;
            s1_hit     <= 1'b0;
        end else begin
            plot_done <= 1'b0;
            s1_hit    <= (state == render_pkg::SPRITE) && !cnt[6] && spr_on;

            case (state)
                render_pkg::IDLE: begin
                    draw_wr_en <= 1'b0;
                    cnt        <= '0;
                    if (plot_start) begin
                        if (tex_code[6]) begin
                            state <= render_pkg::FILL;
                        end else if (tex_code == render_pkg::TEX_SPRITE) begin
                            state <= render_pkg::SPRITE;
                        end else if (tex_code == render_pkg::TEX_DIVIDER) begin
                            state <= render_pkg::LINE;
                        end else begin
                            // Unknown texture, nothing to draw
                            plot_done <= 1'b1;
                        end
                    end
                end
                render_pkg::FILL: begin
                    draw_wr_en <= 1'b1;
                    cnt        <= cnt + 1'b1;
                    if (cnt == render_pkg::fb_addr_t'(render_pkg::FB_DEPTH - 1)) begin
                        state     <= render_pkg::IDLE;
                        plot_done <= 1'b1;
                    end
                end
                render_pkg::SPRITE: begin
                    // Write lags the walk by one ROM read
                    draw_wr_en <= s1_hit && rom_q[6];
                    cnt        <= cnt + 1'b1;
                    if (cnt[6]) begin
                        state     <= render_pkg::IDLE;
                        plot_done <= 1'b1;
                    end
                end
                render_pkg::LINE: begin
                    draw_wr_en <= 1'b1;
                    cnt        <= cnt + 1'b1;
                    if (cnt == render_pkg::fb_addr_t'(render_pkg::SCREEN_H - 1)) begin
                        state     <= render_pkg::IDLE;
                        plot_done <= 1'b1;
                    end
                end
                default: state <= render_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        rom_q   <= sprite_rom[cnt[5:0]];
        s1_addr <= spr_addr;
        case (state)
            render_pkg::FILL: begin
                draw_wr_addr <= cnt;
                draw_wr_data <= tex_code[5:0];
            end
            render_pkg::SPRITE: begin
                draw_wr_addr <= s1_addr;
                if (rom_q[5:0] == render_pkg::KEY_COLOR) begin
                    draw_wr_data <= sprite_color;
                end else begin
                    draw_wr_data <= rom_q[5:0];
                end
            end
            render_pkg::LINE: begin
                draw_wr_addr <= render_pkg::fb_addr_t'(render_pkg::DIVIDER_X
                              * render_pkg::SCREEN_H) + cnt;
                draw_wr_data <= '0;
            end
            default: ;
        endcase
    end

endmodule

// ==== logic/render.sv ====
`timescale 1ns/1ps

module render (
    input  logic                  clk,
    input  logic                  rst_n,
    input  render_pkg::reg_addr_t slave_address,
    input  logic                  slave_read,
    input  logic                  slave_write,
    input  render_pkg::bus_word_t slave_writedata,
    output render_pkg::bus_word_t slave_readdata,
    output logic                  slave_waitrequest,
    input  render_pkg::pix_x_t    pixel_x,
    input  render_pkg::pix_y_t    pixel_y,
    output render_pkg::channel_t  red,
    output render_pkg::channel_t  green,
    output render_pkg::channel_t  blue
);

    // Command handshake between the register block and the engines
    logic plot_start;
    logic plot_done;
    logic flush_start;
    logic flush_done;

    // Drawing configuration
    render_pkg::coord_t    mid_x;
    render_pkg::coord_t    mid_y;
    render_pkg::tex_code_t tex_code;
    render_pkg::pixel_t    sprite_color;

    // Draw buffer ports
    logic                 draw_wr_en;
    render_pkg::fb_addr_t draw_wr_addr;
    render_pkg::pixel_t   draw_wr_data;
    render_pkg::fb_addr_t draw_rd_addr;
    render_pkg::pixel_t   draw_rd_data;

    // Display buffer ports
    logic                 disp_wr_en;
    render_pkg::fb_addr_t disp_wr_addr;
    render_pkg::pixel_t   disp_wr_data;
    render_pkg::fb_addr_t disp_rd_addr;
    render_pkg::pixel_t   disp_rd_data;

    render_regs u_regs (
        .clk               (clk),
        .rst_n             (rst_n),
        .slave_address     (slave_address),
        .slave_read        (slave_read),
        .slave_write       (slave_write),
        .slave_writedata   (slave_writedata),
        .slave_readdata    (slave_readdata),
        .slave_waitrequest (slave_waitrequest),
        .plot_done         (plot_done),
        .flush_done        (flush_done),
        .plot_start        (plot_start),
        .flush_start       (flush_start),
        .mid_x             (mid_x),
        .mid_y             (mid_y),
        .tex_code          (tex_code),
        .sprite_color      (sprite_color)
    );

    plot_engine u_plot (
        .clk          (clk),
        .rst_n        (rst_n),
        .plot_start   (plot_start),
        .mid_x        (mid_x),
        .mid_y        (mid_y),
        .tex_code     (tex_code),
        .sprite_color (sprite_color),
        .plot_done    (plot_done),
        .draw_wr_en   (draw_wr_en),
        .draw_wr_addr (draw_wr_addr),
        .draw_wr_data (draw_wr_data)
    );

    frame_flush u_flush (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_start  (flush_start),
        .flush_done   (flush_done),
        .draw_rd_addr (draw_rd_addr),
        .draw_rd_data (draw_rd_data),
        .disp_wr_en   (disp_wr_en),
        .disp_wr_addr (disp_wr_addr),
        .disp_wr_data (disp_wr_data)
    );

    frame_ram #(
        .DEPTH (render_pkg::FB_DEPTH),
        .WIDTH ($bits(render_pkg::pixel_t))
    ) draw_buf (
        .clk     (clk),
        .wr_en   (draw_wr_en),
        .wr_addr (draw_wr_addr),
        .rd_addr (draw_rd_addr),
        .wr_data (draw_wr_data),
        .rd_data (draw_rd_data)
    );

    frame_ram #(
        .DEPTH (render_pkg::FB_DEPTH),
        .WIDTH ($bits(render_pkg::pixel_t))
    ) disp_buf (
        .clk     (clk),
        .wr_en   (disp_wr_en),
        .wr_addr (disp_wr_addr),
        .rd_addr (disp_rd_addr),
        .wr_data (disp_wr_data),
        .rd_data (disp_rd_data)
    );

    pixel_out u_pixel (
        .clk          (clk),
        .rst_n        (rst_n),
        .pixel_x      (pixel_x),
        .pixel_y      (pixel_y),
        .disp_rd_addr (disp_rd_addr),
        .disp_rd_data (disp_rd_data),
        .red          (red),
        .green        (green),
        .blue         (blue)
    );

endmodule

// ==== logic/render_pkg.sv ====
package render_pkg;

    // Vector types with a meaning of their own
    typedef logic signed [13:0] coord_t;
    typedef logic [16:0]        fb_addr_t;
    typedef logic [5:0]         pixel_t;
    typedef logic [6:0]         texel_t;
    typedef logic [6:0]         tex_code_t;
    typedef logic [7:0]         channel_t;
    typedef logic [3:0]         reg_addr_t;
    typedef logic [31:0]        bus_word_t;
    typedef logic [8:0]         pix_x_t;
    typedef logic [7:0]         pix_y_t;

    // Screen geometry, frame stored column-major
    localparam int SCREEN_W    = 320;
    localparam int SCREEN_H    = 240;
    localparam int FB_DEPTH    = 76800;
    localparam int SPRITE_SIZE = 8;
    localparam int SPRITE_HALF = 4;
    localparam int DIVIDER_X   = 159;

    // Sprite colour that is swapped for the programmed one
    localparam pixel_t KEY_COLOR            = 6'b010101;
    localparam pixel_t DEFAULT_SPRITE_COLOR = KEY_COLOR;

    // 2-bit channel to 8-bit channel (255 / 3)
    localparam int COLOR_SCALE = 85;

    // Slave register map
    localparam reg_addr_t REG_MID_X        = 4'd1;
    localparam reg_addr_t REG_MID_Y        = 4'd2;
    localparam reg_addr_t REG_NEGATIVE     = 4'd3;
    localparam reg_addr_t REG_TEX_CODE     = 4'd4;
    localparam reg_addr_t REG_PARITY       = 4'd5;
    localparam reg_addr_t REG_START        = 4'd6;
    localparam reg_addr_t REG_SPRITE_COLOR = 4'd7;
    localparam reg_addr_t REG_PRESENT      = 4'd8;

    // Texture codes; bit 6 set means fill with the low 6 bits
    localparam tex_code_t TEX_SPRITE  = 7'd1;
    localparam tex_code_t TEX_DIVIDER = 7'd31;

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        SPRITE,
        LINE
    } plot_state_t;

endpackage

// ==== logic/render_regs.sv ====
`timescale 1ns/1ps

module render_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  render_pkg::reg_addr_t slave_address,
    input  logic                  slave_read,
    input  logic                  slave_write,
    input  render_pkg::bus_word_t slave_writedata,
    output render_pkg::bus_word_t slave_readdata,
    output logic                  slave_waitrequest,
    input  logic                  plot_done,
    input  logic                  flush_done,
    output logic                  plot_start,
    output logic                  flush_start,
    output render_pkg::coord_t    mid_x,
    output render_pkg::coord_t    mid_y,
    output render_pkg::tex_code_t tex_code,
    output render_pkg::pixel_t    sprite_color
);

    logic               negative;
    logic               parity;
    logic               wr_accept;
    logic               rd_accept;
    render_pkg::coord_t wr_x;
    render_pkg::coord_t wr_y;

    // Nothing is taken from the bus while a command is running
    assign wr_accept = slave_write && !slave_waitrequest;
    assign rd_accept = slave_read && !slave_waitrequest;

    // Raw coordinate fields, zero extended
    assign wr_x = render_pkg::coord_t'(slave_writedata[8:0]);
    assign wr_y = render_pkg::coord_t'(slave_writedata[7:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid_x             <= '0;
            mid_y             <= '0;
            negative          <= 1'b0;
            tex_code          <= '0;
            sprite_color      <= render_pkg::DEFAULT_SPRITE_COLOR;
            plot_start        <= 1'b0;
            flush_start       <= 1'b0;
            slave_waitrequest <= 1'b0;
            slave_readdata    <= '0;
            parity            <= 1'b0;
        end else begin
            plot_start  <= 1'b0;
            flush_start <= 1'b0;

            if (wr_accept) begin
                case (slave_address)
                    render_pkg::REG_MID_X:        mid_x <= negative ? -wr_x : wr_x;
                    render_pkg::REG_MID_Y:        mid_y <= negative ? -wr_y : wr_y;
                    render_pkg::REG_NEGATIVE:     negative <= slave_writedata[0];
                    render_pkg::REG_TEX_CODE:     tex_code <= slave_writedata[6:0];
                    render_pkg::REG_SPRITE_COLOR: sprite_color <= slave_writedata[5:0];
                    render_pkg::REG_START: begin
                        plot_start        <= 1'b1;
                        slave_waitrequest <= 1'b1;
                    end
                    render_pkg::REG_PRESENT: begin
                        flush_start       <= 1'b1;
                        slave_waitrequest <= 1'b1;
                    end
                    default: ;
                endcase
            end

            // Only one command is in flight, so either done ends it
            if (plot_done || flush_done) begin
                slave_waitrequest <= 1'b0;
            end
            if (flush_done) begin
                parity <= ~parity;
            end

            if (rd_accept) begin
                if (slave_address == render_pkg::REG_PARITY) begin
                    slave_readdata <= render_pkg::bus_word_t'(parity);
                end else begin
                    slave_readdata <= '0;
                end
            end
        end
    end

endmodule

// ==== logic/sprite.hex ====
// One texel per line, column-major, index = column * 8 + row
// Bit 6 set draws the texel, bits 5:0 hold the RR_GG_BB colour
00
00
00
55
55
00
00
00
00
00
55
55
55
55
00
00
00
55
7C
55
55
7C
55
00
40
55
7C
7C
7C
7C
55
40
40
55
7F
40
7C
7C
55
40
00
55
7F
7F
7C
70
55
00
00
00
55
7C
70
70
15
00
00
00
00
70
70
00
00
00

// ==== render.f ====
logic/render_pkg.sv
logic/frame_ram.sv
logic/render_regs.sv
logic/plot_engine.sv
logic/frame_flush.sv
logic/pixel_out.sv
logic/render.sv
verification/render_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the render testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module render_tb -f render.f \
    && ./obj_dir/Vrender_tb | awk '{ print } /^TB PASSED$/ { ok = 1 } END { exit !ok }' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== verification/render_tb.sv ====
`timescale 1ns/1ps

module render_tb;

    logic                  clk;
    logic                  rst_n;
    render_pkg::reg_addr_t slave_address;
    logic                  slave_read;
    logic                  slave_write;
    render_pkg::bus_word_t slave_writedata;
    render_pkg::bus_word_t slave_readdata;
    logic                  slave_waitrequest;
    render_pkg::pix_x_t    pixel_x;
    render_pkg::pix_y_t    pixel_y;
    render_pkg::channel_t  red;
    render_pkg::channel_t  green;
    render_pkg::channel_t  blue;

    // Reference model of both frames and the register state
    render_pkg::pixel_t    draw_model [render_pkg::FB_DEPTH];
    render_pkg::pixel_t    disp_model [render_pkg::FB_DEPTH];
    render_pkg::texel_t    sprite_tex [render_pkg::SPRITE_SIZE * render_pkg::SPRITE_SIZE];
    int                    m_mid_x;
    int                    m_mid_y;
    logic                  m_negative;
    render_pkg::tex_code_t m_tex;
    render_pkg::pixel_t    m_color;
    logic                  m_parity;

    int cycle_count;
    int last_x;
    int last_y;
    int centres_x[$];
    int centres_y[$];

    render dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .slave_address     (slave_address),
        .slave_read        (slave_read),
        .slave_write       (slave_write),
        .slave_writedata   (slave_writedata),
        .slave_readdata    (slave_readdata),
        .slave_waitrequest (slave_waitrequest),
        .pixel_x           (pixel_x),
        .pixel_y           (pixel_y),
        .red               (red),
        .green             (green),
        .blue              (blue)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Six fills and six flushes fit well inside this many cycles
    initial begin
        cycle_count = 0;
        while (cycle_count < 2000000) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_count);
        abort_run();
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_channel(input render_pkg::channel_t expected,
                                 input render_pkg::channel_t actual,
                                 input string name);
        if (actual !== expected) begin
            $display("ERR t=%0t %s expected %0d got %0d", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_readdata(input render_pkg::bus_word_t expected,
                                  input render_pkg::bus_word_t actual);
        if (actual !== expected) begin
            $display("ERR t=%0t slave_readdata expected 0x%08h got 0x%08h",
                     $time, expected, actual);
            abort_run();
        end
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic bit on_screen(input int x, input int y);
        return x >= 0 && x < render_pkg::SCREEN_W && y >= 0 && y < render_pkg::SCREEN_H;
    endfunction

    // Column-major frame address
    function automatic int fb_index(input int x, input int y);
        return x * render_pkg::SCREEN_H + y;
    endfunction

    // Full-scale 2-bit channel maps to 255
    function automatic render_pkg::channel_t expand_channel(input logic [1:0] c);
        return {4{c}};
    endfunction

    task automatic model_plot();
        render_pkg::texel_t t;
        int                 x;
        int                 y;
        if (m_tex[6]) begin
            for (int a = 0; a < render_pkg::FB_DEPTH; a++) begin
                draw_model[a] = m_tex[5:0];
            end
        end else if (m_tex == render_pkg::TEX_SPRITE) begin
            for (int c = 0; c < render_pkg::SPRITE_SIZE; c++) begin
                for (int r = 0; r < render_pkg::SPRITE_SIZE; r++) begin
                    t = sprite_tex[c * render_pkg::SPRITE_SIZE + r];
                    x = m_mid_x - render_pkg::SPRITE_HALF + c;
                    y = m_mid_y - render_pkg::SPRITE_HALF + r;
                    if (t[6] && on_screen(x, y)) begin
                        if (t[5:0] == render_pkg::KEY_COLOR) begin
                            draw_model[fb_index(x, y)] = m_color;
                        end else begin
                            draw_model[fb_index(x, y)] = t[5:0];
                        end
                    end
                end
            end
        end else if (m_tex == render_pkg::TEX_DIVIDER) begin
            for (int r = 0; r < render_pkg::SCREEN_H; r++) begin
                draw_model[fb_index(render_pkg::DIVIDER_X, r)] = '0;
            end
        end
    endtask

    task automatic model_reg_write(input render_pkg::reg_addr_t addr,
                                   input render_pkg::bus_word_t data);
        int mag_x;
        int mag_y;
        mag_x = int'(data[8:0]);
        mag_y = int'(data[7:0]);
        case (addr)
            render_pkg::REG_MID_X:        m_mid_x = m_negative ? -mag_x : mag_x;
            render_pkg::REG_MID_Y:        m_mid_y = m_negative ? -mag_y : mag_y;
            render_pkg::REG_NEGATIVE:     m_negative = data[0];
            render_pkg::REG_TEX_CODE:     m_tex = data[6:0];
            render_pkg::REG_SPRITE_COLOR: m_color = data[5:0];
            render_pkg::REG_START:        model_plot();
            render_pkg::REG_PRESENT: begin
                disp_model = draw_model;
                m_parity   = ~m_parity;
            end
            default: ;
        endcase
    endtask

    task automatic bus_write(input render_pkg::reg_addr_t addr,
                             input render_pkg::bus_word_t data);
        while (slave_waitrequest) begin
            step_cycle();
        end
        slave_address   = addr;
        slave_writedata = data;
        slave_write     = 1'b1;
        step_cycle();
        slave_write     = 1'b0;
        model_reg_write(addr, data);
    endtask

    task automatic bus_read(input render_pkg::reg_addr_t addr,
                            output render_pkg::bus_word_t data);
        while (slave_waitrequest) begin
            step_cycle();
        end
        slave_address = addr;
        slave_read    = 1'b1;
        step_cycle();
        slave_read    = 1'b0;
        data          = slave_readdata;
    endtask

    task automatic wait_command_done();
        if (!slave_waitrequest) begin
            $display("Command was not taken: slave_waitrequest stayed low after the write");
            abort_run();
        end else begin
            while (slave_waitrequest) begin
                step_cycle();
            end
        end
    endtask

    task automatic plot(input render_pkg::tex_code_t code);
        bus_write(render_pkg::REG_TEX_CODE, render_pkg::bus_word_t'(code));
        bus_write(render_pkg::REG_START, '0);
        wait_command_done();
    endtask

    task automatic present_frame();
        render_pkg::bus_word_t rd;
        bus_write(render_pkg::REG_PRESENT, '0);
        wait_command_done();
        bus_read(render_pkg::REG_PARITY, rd);
        check_readdata(render_pkg::bus_word_t'(m_parity), rd);
        // Every other address reads zero whatever the parity
        for (int a = 0; a < 16; a++) begin
            if (render_pkg::reg_addr_t'(a) != render_pkg::REG_PARITY) begin
                bus_read(render_pkg::reg_addr_t'(a), rd);
                check_readdata('0, rd);
            end
        end
    endtask

    // Each coordinate goes through the negative flag as its own sign
    task automatic set_centre(input int x, input int y);
        bus_write(render_pkg::REG_NEGATIVE, render_pkg::bus_word_t'(x < 0));
        bus_write(render_pkg::REG_MID_X, render_pkg::bus_word_t'(x < 0 ? -x : x));
        bus_write(render_pkg::REG_NEGATIVE, render_pkg::bus_word_t'(y < 0));
        bus_write(render_pkg::REG_MID_Y, render_pkg::bus_word_t'(y < 0 ? -y : y));
    endtask

    task automatic sample_pixel(input int x, input int y);
        render_pkg::pixel_t p;
        // Read-out only refreshes on a coordinate change
        if (x == last_x && y == last_y) begin
            pixel_x = render_pkg::pix_x_t'(x == 0 ? 1 : 0);
            repeat (4) step_cycle();
        end
        pixel_x = render_pkg::pix_x_t'(x);
        pixel_y = render_pkg::pix_y_t'(y);
        last_x  = x;
        last_y  = y;
        repeat (4) step_cycle();
        p = disp_model[fb_index(x, y)];
        check_channel(expand_channel(p[5:4]), red, "red");
        check_channel(expand_channel(p[3:2]), green, "green");
        check_channel(expand_channel(p[1:0]), blue, "blue");
    endtask

    // Sprite window, plus the frame words that off-screen spots would alias
    task automatic sample_window(input int cx, input int cy);
        int a;
        for (int dx = -5; dx < 5; dx++) begin
            for (int dy = -5; dy < 5; dy++) begin
                if (on_screen(cx + dx, cy + dy)) begin
                    sample_pixel(cx + dx, cy + dy);
                end else begin
                    a = fb_index(cx + dx, cy + dy);
                    if (a >= 0 && a < render_pkg::FB_DEPTH) begin
                        sample_pixel(a / render_pkg::SCREEN_H, a % render_pkg::SCREEN_H);
                    end
                end
            end
        end
    endtask

    initial begin
        render_pkg::bus_word_t rd;
        int                    y;
        void'($urandom(7886));
        $readmemh("logic/sprite.hex", sprite_tex);
        rst_n           = 1'b0;
        slave_address   = '0;
        slave_read      = 1'b0;
        slave_write     = 1'b0;
        slave_writedata = '0;
        pixel_x         = '0;
        pixel_y         = '0;
        m_mid_x         = 0;
        m_mid_y         = 0;
        m_negative      = 1'b0;
        m_tex           = '0;
        m_color         = render_pkg::DEFAULT_SPRITE_COLOR;
        m_parity        = 1'b0;
        last_x          = -1;
        last_y          = -1;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        step_cycle();

        // Parity starts clear and unused addresses read zero
        bus_read(render_pkg::REG_PARITY, rd);
        check_readdata('0, rd);
        bus_read(4'd0, rd);
        check_readdata('0, rd);
        bus_read(render_pkg::REG_MID_X, rd);
        check_readdata('0, rd);
        bus_read(4'd15, rd);
        check_readdata('0, rd);

        // RAMs start unknown, so a full fill comes first
        plot(render_pkg::tex_code_t'(7'h40 | $urandom_range(63)));
        present_frame();
        repeat (64) sample_pixel($urandom_range(319), $urandom_range(239));

        // Clipped corners and negative centres, then random ones
        centres_x.push_back(1);
        centres_y.push_back(2);
        centres_x.push_back(318);
        centres_y.push_back(237);
        centres_x.push_back(-3);
        centres_y.push_back(120);
        centres_x.push_back(200);
        centres_y.push_back(-2);
        repeat (4) begin
            centres_x.push_back(int'($urandom_range(331)) - 6);
            centres_y.push_back(int'($urandom_range(251)) - 6);
        end
        foreach (centres_x[i]) begin
            // First sprite keeps the reset colour
            if (i > 0) begin
                bus_write(render_pkg::REG_SPRITE_COLOR,
                          render_pkg::bus_word_t'($urandom_range(63)));
            end
            set_centre(centres_x[i], centres_y[i]);
            plot(render_pkg::TEX_SPRITE);
        end
        present_frame();
        foreach (centres_x[i]) begin
            sample_window(centres_x[i], centres_y[i]);
        end

        plot(render_pkg::TEX_DIVIDER);
        present_frame();
        repeat (32) begin
            y = int'($urandom_range(239));
            sample_pixel(render_pkg::DIVIDER_X, y);
            check_channel('0, red, "red");
            check_channel('0, green, "green");
            check_channel('0, blue, "blue");
            sample_pixel(render_pkg::DIVIDER_X - 1, y);
            sample_pixel(render_pkg::DIVIDER_X + 1, y);
        end

        // A fill without present must not reach the display
        plot(render_pkg::tex_code_t'(7'h40 | $urandom_range(63, 1)));
        repeat (32) sample_pixel($urandom_range(319), $urandom_range(239));

        // Unknown texture code completes and draws nothing
        plot(render_pkg::tex_code_t'($urandom_range(30, 2)));
        present_frame();
        repeat (64) sample_pixel($urandom_range(319), $urandom_range(239));
        // Where a divider or a sprite would have landed
        repeat (16) sample_pixel(render_pkg::DIVIDER_X, $urandom_range(239));
        sample_window(centres_x[$], centres_y[$]);

        $display("TB PASSED");
        $finish;
    end

endmodule
